/* beat_counter.sv */
`timescale 1ns/100ps

module beat_counter (
   input  logic              clk,
   input  logic              reset,
   input  logic              load,
   input  stream_pkg::len_t  load_value,
   input  logic              step,
   output logic              last
);

   import stream_pkg::*;

   len_t count;

   // load takes priority over step.
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (load) begin
         count <= load_value;
      end else if (step) begin
         count <= count - len_t'(1);
      end
   end

   // one word left in the frame.
   assign last = (count == len_t'(1));

   a_no_step_zero: assert property (
      @(posedge clk) disable iff (reset)
      (step && !load) |-> (count != '0)
   );

endmodule

/* core_pool.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module core_pool (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    claim,
   input  stream_pkg::core_id_t    claim_id,
   input  logic [`STREAM_CORES-1:0] core_done,
   output logic                    core_valid,
   output stream_pkg::core_id_t    core_id
);

   import stream_pkg::*;

   logic [`STREAM_CORES-1:0] busy;

   // claim wins over a done for the same core.
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= '0;
      end else begin
         busy <= busy & ~core_done;
         if (claim) begin
            busy[claim_id] <= 1'b1;
         end
      end
   end

   // lowest idle core.
   // scan from the top so the lowest index lands last.
   always_comb begin
      core_id    = '0;
      core_valid = 1'b0;
      for (int i = `STREAM_CORES - 1; i >= 0; i--) begin
         if (!busy[i]) begin
            core_id    = core_id_t'(i);
            core_valid = 1'b1;
         end
      end
   end

   a_claim_idle: assert property (
      @(posedge clk) disable iff (reset)
      claim |-> !busy[claim_id]
   );

endmodule

/* recv_fifo.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module recv_fifo (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      wr_en,
   input  logic [`STREAM_DATA_W-1:0] wr_data,
   output logic                      full,
   input  logic                      rdreq,
   output logic [`STREAM_DATA_W-1:0] q,
   output logic                      valid,
   output stream_pkg::level_t        rdusedw
);

   import stream_pkg::*;

   localparam int PTR_W = $clog2(`STREAM_FIFO_DEPTH);

   logic [`STREAM_DATA_W-1:0] mem [`STREAM_FIFO_DEPTH];
   logic [PTR_W-1:0]          wr_ptr;
   logic [PTR_W-1:0]          rd_ptr;
   level_t                    count;
   logic                      wr_ok;
   logic                      rd_ok;

   assign full    = (count == level_t'(`STREAM_FIFO_DEPTH));
   assign valid   = (count != '0);
   assign wr_ok   = wr_en && !full;
   assign rd_ok   = rdreq && valid;
   assign rdusedw = count;

   // the head word is always on q.
   assign q = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // pointers wrap on their own since depth is a power of two.
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_read_empty: assert property (
      @(posedge clk) disable iff (reset)
      rdreq |-> valid
   );

   // a write into a full FIFO must not change the level.
   a_no_write_full: assert property (
      @(posedge clk) disable iff (reset)
      (wr_en && full && !rdreq) |=> (rdusedw == $past(rdusedw))
   );

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f src.f \
   --top-module tb_stream_dispatch -o tb_stream_dispatch ||
   { echo "verilator build failed"; exit 1; }
./obj_dir/tb_stream_dispatch > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: no pass line in log"; exit 1; }
echo "PASS"

/* src.f */
+incdir+.
stream_pkg.sv
recv_fifo.sv
core_pool.sv
beat_counter.sv
stream_data_parser.sv
stream_dispatch_top.sv
tb_stream_dispatch.sv

/* stream_cfg.svh */
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// width of one stream word in bits.
`define STREAM_DATA_W 128

// number of cores fed by the dispatcher.
`define STREAM_CORES 4

// receive FIFO depth in words, a power of two.
`define STREAM_FIFO_DEPTH 64

`endif

/* stream_data_parser.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module stream_data_parser (
   input  logic                      clk,
   input  logic                      reset,

   output logic                      recv_fifo_rdreq,
   input  logic [`STREAM_DATA_W-1:0] recv_fifo_q,
   input  stream_pkg::level_t        recv_fifo_rdusedw,
   input  logic                      recv_fifo_valid,

   input  logic                      core_valid,
   input  stream_pkg::core_id_t      core_id,

   output stream_pkg::core_id_t      target_core,
   output logic                      target_core_valid,
   output logic                      target_snk_sop,
   output logic                      target_snk_eop,
   output logic                      target_snk_valid,
   output logic [`STREAM_DATA_W-1:0] target_snk_data,

   output logic                      loader_kick,
   output logic [63:0]               loader_memory_base_addr
);

   import stream_pkg::*;

   parser_state_t state;
   len_t          header_len;
   logic [31:0]   data_id;
   logic          start;
   logic          single;
   logic          last;

   // header word holds the length in [31:0] and the identifier in [63:32].
   assign header_len = recv_fifo_q[31:0];
   assign single     = (header_len == len_t'(1));

   // the whole frame has to sit in the FIFO before it starts.
   assign start = (state == PARSE_IDLE) && core_valid && recv_fifo_valid
                  && (len_t'(recv_fifo_rdusedw) >= header_len)
                  && (header_len != '0);

   assign recv_fifo_rdreq = start || (state == PARSE_STREAM);

   beat_counter beat_counter_inst (
      .clk        (clk),
      .reset      (reset),
      .load       (start),
      .load_value (header_len - len_t'(1)),
      .step       (state == PARSE_STREAM),
      .last       (last)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         state             <= PARSE_IDLE;
         target_snk_sop    <= 1'b0;
         target_snk_eop    <= 1'b0;
         target_snk_valid  <= 1'b0;
         target_core_valid <= 1'b0;
         loader_kick       <= 1'b0;
      end else begin
         target_snk_sop    <= start;
         target_core_valid <= start;
         target_snk_valid  <= recv_fifo_rdreq;
         target_snk_eop    <= (start && single) || ((state == PARSE_STREAM) && last);
         loader_kick       <= (state == PARSE_KICK);
         case (state)
            PARSE_IDLE: begin
               if (start) begin
                  state <= single ? PARSE_KICK : PARSE_STREAM;
               end
            end
            PARSE_STREAM: begin
               if (last) begin
                  state <= PARSE_KICK;
               end
            end
            PARSE_KICK: begin
               state <= PARSE_IDLE;
            end
            default: begin
               state <= PARSE_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         target_core <= core_id;
         data_id     <= recv_fifo_q[63:32];
      end
      if (recv_fifo_rdreq) begin
         target_snk_data <= recv_fifo_q;
      end
      // base address is the identifier times 32k and is held after the kick.
      if (state == PARSE_KICK) begin
         loader_memory_base_addr <= {17'b0, data_id, 15'b0};
      end
   end

   a_sop_valid: assert property (
      @(posedge clk) disable iff (reset)
      target_snk_sop |-> target_snk_valid
   );

   a_kick_idle: assert property (
      @(posedge clk) disable iff (reset)
      loader_kick |-> !target_snk_valid
   );

endmodule

/* stream_dispatch_top.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module stream_dispatch_top (
   input  logic                      clk,
   input  logic                      reset,

   input  logic                      wr_en,
   input  logic [`STREAM_DATA_W-1:0] wr_data,
   output logic                      wr_full,

   input  logic [`STREAM_CORES-1:0]  core_done,

   output stream_pkg::core_id_t      target_core,
   output logic                      target_core_valid,
   output logic                      target_snk_sop,
   output logic                      target_snk_eop,
   output logic                      target_snk_valid,
   output logic [`STREAM_DATA_W-1:0] target_snk_data,

   output logic                      loader_kick,
   output logic [63:0]               loader_memory_base_addr
);

   import stream_pkg::*;

   logic                      recv_fifo_rdreq;
   logic [`STREAM_DATA_W-1:0] recv_fifo_q;
   logic                      recv_fifo_valid;
   level_t                    recv_fifo_rdusedw;
   logic                      core_valid;
   core_id_t                  core_id;

   recv_fifo recv_fifo_inst (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .full    (wr_full),
      .rdreq   (recv_fifo_rdreq),
      .q       (recv_fifo_q),
      .valid   (recv_fifo_valid),
      .rdusedw (recv_fifo_rdusedw)
   );

   // the first-beat core strobe doubles as the pool claim.
   core_pool core_pool_inst (
      .clk        (clk),
      .reset      (reset),
      .claim      (target_core_valid),
      .claim_id   (target_core),
      .core_done  (core_done),
      .core_valid (core_valid),
      .core_id    (core_id)
   );

   stream_data_parser stream_data_parser_inst (
      .clk                     (clk),
      .reset                   (reset),
      .recv_fifo_rdreq         (recv_fifo_rdreq),
      .recv_fifo_q             (recv_fifo_q),
      .recv_fifo_rdusedw       (recv_fifo_rdusedw),
      .recv_fifo_valid         (recv_fifo_valid),
      .core_valid              (core_valid),
      .core_id                 (core_id),
      .target_core             (target_core),
      .target_core_valid       (target_core_valid),
      .target_snk_sop          (target_snk_sop),
      .target_snk_eop          (target_snk_eop),
      .target_snk_valid        (target_snk_valid),
      .target_snk_data         (target_snk_data),
      .loader_kick             (loader_kick),
      .loader_memory_base_addr (loader_memory_base_addr)
   );

endmodule

/* stream_golden.txt */
// per frame a control word, then the frame words in write order (128-bit hex).
// control [127:64] base address, [31:24] core_done mask, [23:16] gapped, [15:8] core, [7:0] words.
// frame word 0 is the header with [63:32] identifier and [31:0] length; all zero ends the list.
// single word frame to core 0.
00000000000880000000000000000001
a0a0a0a0a0a0a0a00000001100000001
// four words to core 1.
00000000009180000000000000000104
b1b1b1b1b1b1b1b10000012300000004
11112222333344445555666677778888
89abcdef0123456789abcdef01234567
fedcba9876543210fedcba9876543210
// three words written with gaps, core 2.
0000000055e680000000000000010203
c2c2c2c2c2c2c2c20000abcd00000003
0f0e0d0c0b0a09080706050403020100
deadbeefcafef00d0123456789abcdef
// five words to core 3, identifier msb set.
00004000000080000000000000000305
d3d3d3d3d3d3d3d38000000100000005
ffffffffffffffffffffffffffffffff
00000000000000000000000000000001
5555aaaa5555aaaa5555aaaa5555aaaa
13579bdf2468ace013579bdf2468ace0
// all cores busy, waits until core 2 is freed.
00000000002100000000000004000202
e4e4e4e4e4e4e4e40000004200000002
0123456789abcdeffedcba9876543210
// frees cores 0, 1 and 3, goes to core 0.
00000000ffff8000000000000b000001
f5f5f5f5f5f5f5f50001ffff00000001
// three words to core 1.
00003fffffff80000000000000000103
a6a6a6a6a6a6a6a67fffffff00000003
aaaaaaaa55555555aaaaaaaa55555555
00000001000000020000000300000004
00000000000000000000000000000000

/* stream_pkg.sv */
`include "stream_cfg.svh"

package stream_pkg;

   localparam int CORE_ID_W = $clog2(`STREAM_CORES);
   localparam int LEVEL_W = $clog2(`STREAM_FIFO_DEPTH) + 1;

   typedef logic [CORE_ID_W-1:0] core_id_t;

   // one extra bit so a full FIFO can be counted.
   typedef logic [LEVEL_W-1:0] level_t;

   typedef logic [31:0] len_t;

   typedef enum logic [1:0] {
      PARSE_IDLE,
      PARSE_STREAM,
      PARSE_KICK
   } parser_state_t;

endpackage

/* tb_stream_dispatch.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module tb_stream_dispatch;

   import stream_pkg::*;

   localparam int GOLDEN_DEPTH = 64;
   localparam int WAIT_LIMIT   = 200;
   localparam int GAP_CYCLES   = 3;
   localparam int HOLD_CYCLES  = 8;

   logic                      clk;
   logic                      reset;
   logic                      wr_en;
   logic [`STREAM_DATA_W-1:0] wr_data;
   logic                      wr_full;
   logic [`STREAM_CORES-1:0]  core_done;
   core_id_t                  target_core;
   logic                      target_core_valid;
   logic                      target_snk_sop;
   logic                      target_snk_eop;
   logic                      target_snk_valid;
   logic [`STREAM_DATA_W-1:0] target_snk_data;
   logic                      loader_kick;
   logic [63:0]               loader_memory_base_addr;

   logic [127:0]              golden [GOLDEN_DEPTH];
   logic [127:0]              frame_q [$];

   // sink beats and kicks as seen by the monitor.
   logic [127:0]              beat_data_q [$];
   logic [2:0]                beat_flag_q [$];
   core_id_t                  beat_core_q [$];
   int                        beat_cyc_q [$];
   int                        kick_cyc_q [$];
   logic [63:0]               kick_addr_q [$];

   int                        cycle;
   int                        errors;
   int                        checks;
   int                        frames_run;
   logic                      aborted;

   stream_dispatch_top stream_dispatch_top_inst (
      .clk                     (clk),
      .reset                   (reset),
      .wr_en                   (wr_en),
      .wr_data                 (wr_data),
      .wr_full                 (wr_full),
      .core_done               (core_done),
      .target_core             (target_core),
      .target_core_valid       (target_core_valid),
      .target_snk_sop          (target_snk_sop),
      .target_snk_eop          (target_snk_eop),
      .target_snk_valid        (target_snk_valid),
      .target_snk_data         (target_snk_data),
      .loader_kick             (loader_kick),
      .loader_memory_base_addr (loader_memory_base_addr)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // registered outputs are sampled just before they change.
   always @(posedge clk) begin
      if (reset) begin
         cycle = 0;
      end else begin
         cycle = cycle + 1;
         if (target_snk_valid) begin
            beat_data_q.push_back(target_snk_data);
            beat_flag_q.push_back({target_snk_sop, target_snk_eop, target_core_valid});
            beat_core_q.push_back(target_core);
            beat_cyc_q.push_back(cycle);
         end
         if (loader_kick) begin
            kick_cyc_q.push_back(cycle);
            kick_addr_q.push_back(loader_memory_base_addr);
         end
      end
   end

   task automatic compare_value(input string name, input logic [127:0] actual,
                                input logic [127:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, actual, expected);
      end
   endtask

   task automatic idle_cycles(input int count);
      repeat (count) @(negedge clk);
   endtask

   task automatic write_word(input logic [127:0] word);
      int waited;
      waited = 0;
      while (wr_full && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (wr_full) begin
         errors++;
         aborted = 1'b1;
         $display("FIFO stayed full for %0d cycles, write dropped at %0t", waited, $time);
      end else begin
         wr_en   = 1'b1;
         wr_data = word;
         @(negedge clk);
         wr_en   = 1'b0;
      end
   endtask

   task automatic pulse_done(input logic [`STREAM_CORES-1:0] mask);
      core_done = mask;
      @(negedge clk);
      core_done = '0;
   endtask

   task automatic wait_for_kick();
      int waited;
      waited = 0;
      while (kick_cyc_q.size() == 0 && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (kick_cyc_q.size() == 0) begin
         errors++;
         aborted = 1'b1;
         $display("no loader kick for frame %0d within %0d cycles", frames_run, waited);
      end
   endtask

   task automatic check_frame(input int n, input core_id_t exp_core, input logic [63:0] exp_addr);
      int         first;
      int         last_cyc;
      logic [2:0] flags;
      first = 0;
      compare_value("beat count", 128'(beat_data_q.size()), 128'(n));
      compare_value("loader_kick count", 128'(kick_cyc_q.size()), 128'(1));
      if (beat_data_q.size() > 0) begin
         first = beat_cyc_q[0];
         compare_value("target_core", 128'(beat_core_q[0]), 128'(exp_core));
      end
      for (int i = 0; i < beat_data_q.size() && i < n; i++) begin
         flags = beat_flag_q[i];
         compare_value("target_snk_data", beat_data_q[i], frame_q[i]);
         compare_value("target_snk_sop", 128'(flags[2]), 128'(i == 0));
         compare_value("target_snk_eop", 128'(flags[1]), 128'(i == n - 1));
         compare_value("target_core_valid", 128'(flags[0]), 128'(i == 0));
         // beats of one frame are back to back.
         compare_value("target_snk_valid cycle", 128'(beat_cyc_q[i]), 128'(first + i));
      end
      if (kick_cyc_q.size() > 0 && beat_data_q.size() > 0) begin
         last_cyc = beat_cyc_q[beat_cyc_q.size() - 1];
         compare_value("loader_kick cycle", 128'(kick_cyc_q[0]), 128'(last_cyc + 1));
         compare_value("loader_memory_base_addr", 128'(kick_addr_q[0]), 128'(exp_addr));
      end
      beat_data_q.delete();
      beat_flag_q.delete();
      beat_core_q.delete();
      beat_cyc_q.delete();
      kick_cyc_q.delete();
      kick_addr_q.delete();
   endtask

   task automatic run_frame(input logic [127:0] ctrl);
      int                       n;
      logic                     gapped;
      logic [`STREAM_CORES-1:0] release_mask;
      n            = int'(ctrl[7:0]);
      gapped       = ctrl[16];
      release_mask = ctrl[24 +: `STREAM_CORES];
      for (int i = 0; i < n && !aborted; i++) begin
         write_word(frame_q[i]);
         // a partial frame stays in the FIFO.
         if (gapped && i < n - 1) begin
            idle_cycles(GAP_CYCLES);
            compare_value("target_snk_valid before last word", 128'(beat_data_q.size()), 128'(0));
         end
      end
      if (release_mask != '0 && !aborted) begin
         idle_cycles(HOLD_CYCLES);
         compare_value("target_snk_valid with all cores busy", 128'(beat_data_q.size()), 128'(0));
         pulse_done(release_mask);
      end
      if (!aborted) begin
         wait_for_kick();
      end
      idle_cycles(2);
      check_frame(n, core_id_t'(ctrl[15:8]), ctrl[127:64]);
   endtask

   initial begin
      int           idx;
      int           n;
      logic [127:0] ctrl;
      reset      = 1'b1;
      wr_en      = 1'b0;
      wr_data    = '0;
      core_done  = '0;
      errors     = 0;
      checks     = 0;
      frames_run = 0;
      aborted    = 1'b0;
      idx        = 0;
      $readmemh("stream_golden.txt", golden);
      repeat (5) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      compare_value("target_snk_valid", 128'(target_snk_valid), 128'(0));
      compare_value("target_snk_sop", 128'(target_snk_sop), 128'(0));
      compare_value("target_snk_eop", 128'(target_snk_eop), 128'(0));
      compare_value("target_core_valid", 128'(target_core_valid), 128'(0));
      compare_value("loader_kick", 128'(loader_kick), 128'(0));
      compare_value("wr_full", 128'(wr_full), 128'(0));
      // an all-zero control word ends the list.
      while (!aborted && idx < GOLDEN_DEPTH && !$isunknown(golden[idx])
             && golden[idx][7:0] != 8'h00) begin
         ctrl = golden[idx];
         n    = int'(ctrl[7:0]);
         if (idx + n >= GOLDEN_DEPTH) begin
            errors++;
            aborted = 1'b1;
            $display("golden record at entry %0d runs past the end of the file", idx);
         end else begin
            frame_q.delete();
            for (int i = 0; i < n; i++) begin
               frame_q.push_back(golden[idx + 1 + i]);
            end
            idx = idx + n + 1;
            run_frame(ctrl);
            frames_run++;
         end
      end
      if (frames_run == 0) begin
         errors++;
         $display("golden file held no frames");
      end
      $display("frames: %0d, checks: %0d, errors: %0d", frames_run, checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
